// ==== verilog/dcachePkg.sv ====
`default_nettype none

// ====================
// shared constants for the voted data-cache memory
// ====================

package dcachePkg;

	// the store keeps three copies of every word so a two-of-three vote is possible
	localparam int numCopies = 3;

	// byte address where register space starts, memory words live below it
	localparam logic [15:0] regBase = 16'h2000;

	// register byte offsets on the APB bus
	localparam logic [15:0] regFaultSel = 16'h2000;
	localparam logic [15:0] regFaultMask = 16'h2004;
	localparam logic [15:0] regStatus = 16'h2008;

	// one scramble byte per copy, copy 0 in the lowest byte
	// each bank repeats its byte across the whole word
	localparam logic [numCopies-1:0][7:0] scrambleByte = {8'h55, 8'hAA, 8'h00};

endpackage

`default_nettype wire

// ==== verilog/ramPortIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// shared RAM port between the APB controller and the storage banks
// every bank sees the same write and read request at the same time
interface ramPortIf #(
	parameter int DBW = 32,
	parameter int AW = 11
);

	// write side, one strobe per byte lane
	logic we;
	logic [DBW/8-1:0] sel;
	logic [AW-1:0] wa;
	logic [DBW-1:0] wd;

	// read side, the banks register ra when re is high
	logic re;
	logic [AW-1:0] ra;

	// the controller is the only driver of the port
	modport ctrl (output we, output sel, output wa, output wd, output re, output ra);

	// each bank only listens
	modport bank (input we, input sel, input wa, input wd, input re, input ra);

endinterface

`default_nettype wire

// ==== verilog/apbMemCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// APB slave in front of the voted memory
// decodes memory against register space and runs the read wait state
module apbMemCtrl import dcachePkg::*; #(
	parameter int DBW = 32,
	parameter int AW = 11
) (
	input wire logic rclk,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [15:0] paddr,
	input wire logic [DBW-1:0] pwdata,
	input wire logic [DBW/8-1:0] pstrb,
	input wire logic [DBW-1:0] voted,
	input wire logic mismatch,
	output logic [DBW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [numCopies-1:0] faultEn,
	output logic [DBW-1:0] faultMask,
	ramPortIf.ctrl ram
);

	// first byte address past the last register
	localparam logic [15:0] regTop = regStatus + 16'd4;

	typedef enum logic {idle, readWait} stateT;

	stateT state;
	logic rdMem;
	logic [15:0] statusCnt;
	logic [DBW-1:0] regRdata;
	logic setupPhase;
	logic isMem;
	logic isUnmapped;
	logic isReg;

	// ====================
	// address decode
	// ====================

	// a new transfer is only accepted while nothing else is in flight
	assign setupPhase = psel && !penable && (state == idle) && !pready;

	assign isMem = paddr < regBase;
	assign isUnmapped = paddr >= regTop;
	assign isReg = !isMem && !isUnmapped;

	// memory reads return the voted word, everything else the captured register value
	assign prdata = rdMem ? voted : regRdata;

	// ====================
	// phase control
	// ====================

	always_ff @(posedge rclk) begin
		if (!rstN) begin
			state <= idle;
			pready <= 1'b0;
			pslverr <= 1'b0;
			rdMem <= 1'b0;
			ram.we <= 1'b0;
			ram.re <= 1'b0;
			faultEn <= '0;
			faultMask <= '0;
			statusCnt <= '0;
		end else begin
			// we and re are single-cycle pulses
			ram.we <= 1'b0;
			ram.re <= 1'b0;
			case (state)
				idle: begin
					if (pready) begin
						// this edge closes the access cycle that carried pready
						pready <= 1'b0;
						pslverr <= 1'b0;
						rdMem <= 1'b0;
						// only completed memory reads are counted, saturating at all ones
						if (rdMem && mismatch && (statusCnt != 16'hFFFF)) begin
							statusCnt <= statusCnt + 16'd1;
						end
						if (pwrite && isReg) begin
							if (paddr[15:2] == regFaultSel[15:2]) begin
								faultEn <= pwdata[numCopies-1:0];
							end
							if (paddr[15:2] == regFaultMask[15:2]) begin
								faultMask <= pwdata;
							end
							// any write to the status register clears the count
							if (paddr[15:2] == regStatus[15:2]) begin
								statusCnt <= '0;
							end
						end
					end else if (setupPhase) begin
						if (isMem && !pwrite) begin
							// read needs one extra cycle for the bank address register
							state <= readWait;
							ram.re <= 1'b1;
						end else begin
							// writes, register accesses and errors finish in one access cycle
							pready <= 1'b1;
							pslverr <= isUnmapped;
							ram.we <= isMem && pwrite;
						end
					end
				end
				readWait: begin
					// the banks register the address at the end of this cycle
					state <= idle;
					pready <= 1'b1;
					rdMem <= 1'b1;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// ====================
	// request payload
	// ====================

	// address, data and register read value are sampled at the setup edge
	always_ff @(posedge rclk) begin
		if (setupPhase) begin
			ram.wa <= paddr[AW+1:2];
			ram.ra <= paddr[AW+1:2];
			ram.wd <= pwdata;
			ram.sel <= pstrb;
			if (paddr[15:2] == regFaultSel[15:2]) begin
				regRdata <= {{(DBW-numCopies){1'b0}}, faultEn};
			end else if (paddr[15:2] == regFaultMask[15:2]) begin
				regRdata <= faultMask;
			end else if (paddr[15:2] == regStatus[15:2]) begin
				regRdata <= {{(DBW-16){1'b0}}, statusCnt};
			end else begin
				regRdata <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/scrambledBank.sv ====
`timescale 1ns/1ps
`default_nettype none

// one copy of the store, built from byte-lane synchronous RAMs
// data is kept XORed with this copy's key so the copies never hold the same bits
module scrambledBank #(
	parameter int DBW = 32,
	parameter int AW = 11,
	parameter logic [7:0] KEY = 8'h00
) (
	input wire logic rclk,
	input wire logic faultEn,
	input wire logic [DBW-1:0] faultMask,
	ramPortIf.bank ram,
	output logic [DBW-1:0] copyData
);

	localparam int numLanes = DBW / 8;
	localparam int depth = 2 ** AW;

	// registered read address, shared by all lanes
	logic [AW-1:0] raReg;

	// ====================
	// read address register
	// ====================

	always_ff @(posedge rclk) begin
		if (ram.re) begin
			raReg <= ram.ra;
		end
	end

	// ====================
	// byte lanes
	// ====================

	for (genvar lane = 0; lane < numLanes; lane++) begin : gLane
		logic [7:0] mem [depth];
		logic [7:0] laneFault;
		logic [7:0] laneWd;

		// fault injection only touches this copy when its enable bit is set
		assign laneFault = faultEn ? faultMask[lane*8 +: 8] : 8'h00;

		// scramble on the way in
		assign laneWd = ram.wd[lane*8 +: 8] ^ KEY ^ laneFault;

		// each copy powers up holding the scrambled form of zero
		// so an unwritten word reads as zero in every copy and the vote agrees
		initial begin
			for (int w = 0; w < depth; w++) begin
				mem[w] = KEY;
			end
		end

		// lane writes only when its strobe is set
		always_ff @(posedge rclk) begin
			if (ram.we && ram.sel[lane]) begin
				mem[ram.wa] <= laneWd;
			end
		end

		// descramble on the way out, the fault stays visible to the voter
		assign copyData[lane*8 +: 8] = mem[raReg] ^ KEY;
	end

endmodule

`default_nettype wire

// ==== verilog/majorityVoter.sv ====
`timescale 1ns/1ps
`default_nettype none

// bitwise two-of-three vote over the descrambled copies
// purely combinational, the result is valid in the same cycle as the bank outputs
module majorityVoter import dcachePkg::*; #(
	parameter int DBW = 32
) (
	input wire logic [numCopies-1:0][DBW-1:0] copyData,
	output logic [DBW-1:0] voted,
	output logic mismatch
);

	logic [DBW-1:0] copyA;
	logic [DBW-1:0] copyB;
	logic [DBW-1:0] copyC;
	logic [DBW-1:0] diffAB;
	logic [DBW-1:0] diffAC;

	// name the copies so the vote reads like the textbook form
	assign copyA = copyData[0];
	assign copyB = copyData[1];
	assign copyC = copyData[2];

	// ====================
	// vote
	// ====================

	// a bit is set when at least two copies have it set
	assign voted = (copyA & copyB) | (copyA & copyC) | (copyB & copyC);

	// if A matches both B and C then all three agree
	// so two comparisons are enough to catch any disagreement
	assign diffAB = copyA ^ copyB;
	assign diffAC = copyA ^ copyC;

	assign mismatch = (|diffAB) || (|diffAC);

endmodule

`default_nettype wire

// ==== verilog/dcacheVoteTop.sv ====
`timescale 1ns/1ps
`default_nettype none

// top level of the voted data-cache memory
// the controller feeds three scrambled banks in parallel and the voter merges them
module dcacheVoteTop import dcachePkg::*; #(
	parameter int DBW = 32,
	parameter int AW = 11
) (
	// APB clock, named rclk in this design
	input wire logic rclk,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [15:0] paddr,
	input wire logic [DBW-1:0] pwdata,
	input wire logic [DBW/8-1:0] pstrb,
	output logic [DBW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic [numCopies-1:0] faultEn;
	logic [DBW-1:0] faultMask;
	logic [numCopies-1:0][DBW-1:0] copyData;
	logic [DBW-1:0] voted;
	logic mismatch;

	// one shared port, every bank sees the same request
	ramPortIf #(.DBW(DBW), .AW(AW)) ramPort ();

	// ====================
	// bus side
	// ====================

	apbMemCtrl #(
		.DBW(DBW),
		.AW(AW)
	) ctrl (
		.rclk(rclk),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.voted(voted),
		.mismatch(mismatch),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.faultEn(faultEn),
		.faultMask(faultMask),
		.ram(ramPort)
	);

	// ====================
	// storage copies
	// ====================

	// each copy gets its own key byte and its own fault enable bit
	for (genvar c = 0; c < numCopies; c++) begin : gCopy
		scrambledBank #(
			.DBW(DBW),
			.AW(AW),
			.KEY(scrambleByte[c])
		) bank (
			.rclk(rclk),
			.faultEn(faultEn[c]),
			.faultMask(faultMask),
			.ram(ramPort),
			.copyData(copyData[c])
		);
	end

	majorityVoter #(
		.DBW(DBW)
	) voter (
		.copyData(copyData),
		.voted(voted),
		.mismatch(mismatch)
	);

endmodule

`default_nettype wire

// ==== testbench/dcacheVote_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the APB side of the controller
module dcacheVote_props (
	input wire logic rclk,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic we,
	input wire logic re
);

	// ====================
	// APB response
	// ====================

	// the slave may only answer inside an access cycle
	readyInAccess: assert property (@(posedge rclk) disable iff (!rstN)
		pready |-> (psel && penable))
		else $error("pready raised outside an access cycle");

	// an error response is only meaningful together with pready
	errWithReady: assert property (@(posedge rclk) disable iff (!rstN)
		pslverr |-> pready)
		else $error("pslverr raised without pready");

	// the shared RAM port never carries a write and a read in the same cycle
	noWeWithRe: assert property (@(posedge rclk) disable iff (!rstN)
		!(we && re))
		else $error("we and re high together");

endmodule

bind apbMemCtrl dcacheVote_props apbProps (
	.rclk(rclk),
	.rstN(rstN),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.we(ram.we),
	.re(ram.re)
);

`default_nettype wire

// ==== testbench/tbDcacheVote.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDcacheVote import dcachePkg::*; ();

	localparam int opMemWr = 0;
	localparam int opMemRd = 1;
	localparam int opRegWr = 2;
	localparam int opRegRd = 3;
	// first byte address that the slave answers with an error
	localparam logic [15:0] errBase = 16'h200C;

	typedef struct {
		string name;
		int op;
		logic [15:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] expData;
		logic expErr;
	} entryT;

	logic rclk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [3:0] pstrb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	entryT stimTable [$];
	int errors = 0;
	int timeouts = 0;

	// reference state, each copy holds the word as written after any fault
	logic [31:0] shadow [3][2048];
	logic [2:0] mFaultEn;
	logic [31:0] mFaultMask;
	logic [15:0] mCount;

	dcacheVoteTop #(.DBW(32), .AW(11)) i_dut (
		.rclk(rclk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
		.pready(pready), .pslverr(pslverr)
	);

	initial begin
		rclk = 1'b0;
		forever #2 rclk = ~rclk;
	end

	// ====================
	// reference model
	// ====================

	// each bit goes to whichever value at least two copies hold
	function automatic logic [31:0] majority3(input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] c);
		logic [31:0] v;
		int ones;
		for (int k = 0; k < 32; k++) begin
			ones = int'(a[k]) + int'(b[k]) + int'(c[k]);
			v[k] = (ones >= 2);
		end
		return v;
	endfunction

	// adds one table row and advances the model as the DUT should
	function automatic void addEntry(input string name, input int op, input logic [15:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		entryT e;
		int w;
		e.name = name;
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.strb = strb;
		e.expData = '0;
		e.expErr = (addr >= errBase);
		w = int'(addr[12:2]);
		if (!e.expErr && op == opMemWr) begin
			for (int c = 0; c < 3; c++) begin
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						shadow[c][w][b*8 +: 8] = data[b*8 +: 8] ^
							(mFaultEn[c] ? mFaultMask[b*8 +: 8] : 8'h00);
					end
				end
			end
		end else if (!e.expErr && op == opMemRd) begin
			e.expData = majority3(shadow[0][w], shadow[1][w], shadow[2][w]);
			// a read where the copies disagree bumps the status counter
			if ((shadow[0][w] != shadow[1][w] || shadow[0][w] != shadow[2][w])
					&& mCount != 16'hFFFF) begin
				mCount = mCount + 16'd1;
			end
		end else if (!e.expErr && op == opRegWr) begin
			if (addr == regFaultSel) mFaultEn = data[2:0];
			if (addr == regFaultMask) mFaultMask = data;
			if (addr == regStatus) mCount = '0;
		end else if (!e.expErr && op == opRegRd) begin
			if (addr == regFaultSel) e.expData = {29'd0, mFaultEn};
			if (addr == regFaultMask) e.expData = mFaultMask;
			if (addr == regStatus) e.expData = {16'd0, mCount};
		end
		stimTable.push_back(e);
	endfunction

	// ====================
	// APB master
	// ====================

	task automatic apbXfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [31:0] rdata, output logic err,
			output logic done, output int waits);
		int cnt;
		cnt = 0;
		done = 1'b0;
		rdata = '0;
		err = 1'b0;
		@(negedge rclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		pstrb = strb;
		@(negedge rclk);
		penable = 1'b1;
		// reads take one wait state, everything else answers at once
		while (!pready && cnt < 20) begin
			@(negedge rclk);
			cnt++;
		end
		waits = cnt;
		if (pready) begin
			rdata = prdata;
			err = pslverr;
			done = 1'b1;
		end
		@(negedge rclk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// ====================
	// stimulus and checks
	// ====================

	initial begin : mainFlow
		logic [15:0] addrs [4];
		logic [31:0] mask;
		logic [31:0] rdata;
		logic err;
		logic done;
		int waits;
		int expWaits;
		void'($urandom(62036));
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		mFaultEn = '0;
		mFaultMask = '0;
		mCount = '0;
		for (int c = 0; c < 3; c++) begin
			for (int w = 0; w < 2048; w++) begin
				shadow[c][w] = '0;
			end
		end

		// full-strobe words at random addresses, no faults yet
		for (int i = 0; i < 4; i++) begin
			addrs[i] = {3'b000, 11'($urandom), 2'b00};
			addEntry($sformatf("fullWr%0d", i), opMemWr, addrs[i], $urandom, 4'hF);
		end
		for (int i = 0; i < 4; i++) begin
			addEntry($sformatf("fullRd%0d", i), opMemRd, addrs[i], '0, '0);
		end
		addEntry("statusClean", opRegRd, regStatus, '0, '0);

		// only lanes 0 and 2 may change here
		addEntry("partWr", opMemWr, addrs[0], $urandom, 4'b0101);
		addEntry("partRd", opMemRd, addrs[0], '0, '0);

		// one faulted copy is outvoted but still counted
		mask = $urandom | 32'h1;
		addEntry("selOne", opRegWr, regFaultSel, 32'h1, '0);
		addEntry("maskWr", opRegWr, regFaultMask, mask, '0);
		addEntry("maskRd", opRegRd, regFaultMask, '0, '0);
		addEntry("oneFaultWrA", opMemWr, addrs[1], $urandom, 4'hF);
		addEntry("oneFaultWrB", opMemWr, addrs[2], $urandom, 4'hF);
		addEntry("oneFaultRdA", opMemRd, addrs[1], '0, '0);
		addEntry("oneFaultRdB", opMemRd, addrs[2], '0, '0);
		addEntry("statusOne", opRegRd, regStatus, '0, '0);

		// two faulted copies win the vote
		addEntry("selTwo", opRegWr, regFaultSel, 32'h3, '0);
		addEntry("selRd", opRegRd, regFaultSel, '0, '0);
		addEntry("twoFaultWr", opMemWr, addrs[3], $urandom, 4'hF);
		addEntry("twoFaultRd", opMemRd, addrs[3], '0, '0);
		addEntry("statusTwo", opRegRd, regStatus, '0, '0);
		addEntry("statusClr", opRegWr, regStatus, $urandom, '0);
		addEntry("statusZero", opRegRd, regStatus, '0, '0);
		// the stored copies still disagree, so the cleared count starts again from one
		addEntry("twoFaultRdAgain", opMemRd, addrs[3], '0, '0);
		addEntry("selNone", opRegWr, regFaultSel, 32'h0, '0);

		// unmapped accesses must leave memory and registers alone
		// their low address bits line up with the mask and status offsets
		addEntry("errWr", opRegWr, errBase + 16'd8, $urandom, 4'hF);
		addEntry("errClr", opRegWr, errBase + 16'd12, $urandom, 4'hF);
		addEntry("errRd", opRegRd, errBase + 16'd4, '0, '0);
		addEntry("aliasRd", opMemRd, 16'h0014, '0, '0);
		addEntry("maskKept", opRegRd, regFaultMask, '0, '0);
		addEntry("statusKept", opRegRd, regStatus, '0, '0);
		addEntry("finalRd", opMemRd, addrs[0], '0, '0);

		repeat (5) @(negedge rclk);
		rstN = 1'b1;

		foreach (stimTable[i]) begin
			apbXfer(stimTable[i].op == opMemWr || stimTable[i].op == opRegWr,
				stimTable[i].addr, stimTable[i].data, stimTable[i].strb, rdata, err, done,
				waits);
			if (!done) begin
				timeouts++;
				$display("timeout while waiting for pready in entry %s", stimTable[i].name);
			end else begin
				assert (err === stimTable[i].expErr) else begin
					errors++;
					$display("FAIL %s pslverr expected %0b actual %0b", stimTable[i].name,
						stimTable[i].expErr, err);
				end
				// a mapped memory read has one wait state, every other access none
				expWaits = (stimTable[i].op == opMemRd && !stimTable[i].expErr) ? 1 : 0;
				assert (waits == expWaits) else begin
					errors++;
					$display("FAIL %s wait states expected %0d actual %0d",
						stimTable[i].name, expWaits, waits);
				end
				// data is only defined for reads that did not end in an error
				if ((stimTable[i].op == opMemRd || stimTable[i].op == opRegRd)
						&& !stimTable[i].expErr) begin
					assert (rdata === stimTable[i].expData) else begin
						errors++;
						$display("FAIL %s expected %h actual %h", stimTable[i].name,
							stimTable[i].expData, rdata);
					end
				end
			end
		end

		$display("errors: %0d wrong values, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dcacheVote.f ====
verilog/dcachePkg.sv
verilog/ramPortIf.sv
verilog/apbMemCtrl.sv
verilog/scrambledBank.sv
verilog/majorityVoter.sv
verilog/dcacheVoteTop.sv
testbench/dcacheVote_props.sv
testbench/tbDcacheVote.sv

// ==== run.sh ====
#!/bin/sh
# build and run the voted data-cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbDcacheVote \
	-f dcacheVote.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "sim failed" sim.log; then
	echo "testbench reported failure, see sim.log"
	exit 1
fi

echo "testbench reported no failure"
exit 0
